// File: src/pipe_pkg.sv
package pipe_pkg;

	typedef logic [4:0]  reg_idx_t;
	typedef logic [2:0]  func3_t;
	typedef logic [11:0] imm12_t;

	// {mem non-load forward, wb forward}.
	typedef logic [1:0]  fwd_sel_t;

	localparam reg_idx_t ZERO_IDX = 5'd0;
	localparam reg_idx_t RA_IDX   = 5'd1;

	// producing stages from youngest to oldest.
	localparam int N_STAGES = 4;
	localparam int STG_ID   = 0;
	localparam int STG_EX   = 1;
	localparam int STG_MEM  = 2;
	localparam int STG_WB   = 3;

	typedef struct packed {
		reg_idx_t rd;
		logic     reg_write;
		logic     mem_read;
	} stage_src_t;

	typedef struct packed {
		reg_idx_t rs1;
		reg_idx_t rs2;
		reg_idx_t rd;
		func3_t   func3;
		imm12_t   imme;
		logic     i_type;
		logic     b_type;
		logic     jal;
		logic     jalr;
	} id_instr_t;

	typedef struct packed {
		logic rs1_hit;
		logic rs2_hit;
		logic rs1_load;
		logic rs1_noload;
		logic rs2_load;
		logic rs2_noload;
	} stage_hit_t;

	typedef struct packed {
		logic rd_is_ra;
		logic rs1_is_ra;
		logic ras_hit;
		logic track_mv;
	} instr_class_t;

endpackage

// File: src/ras_pkg.sv
package ras_pkg;

	// default width of a return address.
	localparam int RAS_ADDR_W = 32;

	typedef logic [RAS_ADDR_W-1:0] ras_addr_t;

	// one cycle's worth of stack commands.
	// rollback bits only fire under flush and never with push or pop.
	typedef struct packed {
		logic push;
		logic pop;
		logic rb_pop_id;
		logic rb_push_id;
		logic rb_push_ex;
	} ras_cmd_t;

endpackage

// File: src/instr_classify.sv
`timescale 1ns/100ps

module instr_classify
	import pipe_pkg::*;
(
	input  id_instr_t    id_instr,
	input  reg_idx_t     ra_track,
	output instr_class_t iclass
);

	logic imm_nonzero;
	logic imm_zero;
	logic rs1_is_ra;
	logic is_mv;
	logic compliant_ret;
	logic track_hit;

	// ************************************************************
	// immediate and register checks
	// ************************************************************

	// wide or over the 12-bit immediate.
	assign imm_nonzero = |id_instr.imme;
	assign imm_zero    = !imm_nonzero;

	assign rs1_is_ra = (id_instr.rs1 == RA_IDX);

	// ************************************************************
	// mv and return recognition
	// ************************************************************

	// addi rd, rs1, 0.
	assign is_mv = id_instr.i_type && (id_instr.func3 == 3'b000) && imm_zero;

	// jalr x0, ra, 0.
	assign compliant_ret = (id_instr.rd == ZERO_IDX) && rs1_is_ra && imm_zero;

	// jump through a register that still holds a copy of ra.
	assign track_hit = (id_instr.rs1 == ra_track) && !rs1_is_ra;

	assign iclass.rd_is_ra  = (id_instr.rd == RA_IDX);
	assign iclass.rs1_is_ra = rs1_is_ra;
	assign iclass.ras_hit   = compliant_ret || track_hit;
	assign iclass.track_mv  = is_mv && rs1_is_ra;

endmodule

// File: src/stage_hazard_cmp.sv
`timescale 1ns/100ps

module stage_hazard_cmp
	import pipe_pkg::*;
(
	input  reg_idx_t   rs1,
	input  reg_idx_t   rs2,
	input  stage_src_t src,
	output stage_hit_t hit
);

	logic rs1_match;
	logic rs2_match;

	// a stage only counts when it will write its destination.
	assign rs1_match = src.reg_write && (src.rd == rs1);
	assign rs2_match = src.reg_write && (src.rd == rs2);

	assign hit.rs1_hit = rs1_match;
	assign hit.rs2_hit = rs2_match;

	// load results are not ready until after mem.
	assign hit.rs1_load   = rs1_match && src.mem_read;
	assign hit.rs1_noload = rs1_match && !src.mem_read;
	assign hit.rs2_load   = rs2_match && src.mem_read;
	assign hit.rs2_noload = rs2_match && !src.mem_read;

endmodule

// File: src/hazard_resolve.sv
`timescale 1ns/100ps

module hazard_resolve
	import pipe_pkg::*;
(
	input  stage_hit_t   hits [N_STAGES],
	input  id_instr_t    id_instr,
	input  instr_class_t iclass,
	output fwd_sel_t     rs1_fwd,
	output fwd_sel_t     rs2_fwd,
	output logic         b_pred_en,
	output logic         jalr_pred_en,
	output logic         stall_if
);

	stage_hit_t hit_id;
	stage_hit_t hit_ex;
	stage_hit_t hit_mem;
	stage_hit_t hit_wb;

	logic rs1_early;
	logic rs2_early;

	assign hit_id  = hits[STG_ID];
	assign hit_ex  = hits[STG_EX];
	assign hit_mem = hits[STG_MEM];
	assign hit_wb  = hits[STG_WB];

	// ************************************************************
	// forwarding selects
	// ************************************************************

	assign rs1_fwd = {hit_mem.rs1_noload, hit_wb.rs1_hit};
	assign rs2_fwd = {hit_mem.rs2_noload, hit_wb.rs2_hit};

	// ************************************************************
	// early resolution and fetch stall
	// ************************************************************

	// operand not yet visible to the id-stage comparators.
	assign rs1_early = hit_id.rs1_hit || hit_ex.rs1_hit || hit_mem.rs1_load;
	assign rs2_early = hit_id.rs2_hit || hit_ex.rs2_hit || hit_mem.rs2_load;

	// branch outcome is deferred when either operand is still in flight.
	assign b_pred_en = id_instr.b_type && (rs1_early || rs2_early);

	// predicted return target is used while the real rs1 is not ready.
	assign jalr_pred_en = id_instr.jalr && iclass.ras_hit && rs1_early;

	// unpredictable jalr waits a cycle for the ex or load result.
	// an id-stage producer is handled later in ex, so no stall then.
	assign stall_if = id_instr.jalr
		&& !iclass.ras_hit
		&& !hit_id.rs1_hit
		&& (hit_ex.rs1_noload || hit_mem.rs1_load);

endmodule

// File: src/ras_control.sv
`timescale 1ns/100ps

module ras_control
	import pipe_pkg::*;
	import ras_pkg::*;
(
	input  logic         clk,
	input  logic         rst_n,
	input  id_instr_t    id_instr,
	input  instr_class_t iclass,
	input  logic         jal_id,
	input  logic         jalr_id,
	input  reg_idx_t     rd_id,
	input  logic         pl_flush,
	input  logic         pl_stall_ex,
	input  logic         stall_if,
	input  logic         jalr_pred_en,
	input  logic         jalr_data_match,
	output ras_cmd_t     cmd,
	output reg_idx_t     ra_track
);

	logic allow;
	logic pop_now;
	logic push_now;
	logic link_id;

	// pop seen in the previous unstalled cycle and in the one before.
	logic pop_id;
	logic pop_ex;

	// ************************************************************
	// push and pop
	// ************************************************************

	assign allow = !pl_flush && !pl_stall_ex && !stall_if;

	// pop when the stack target is taken or the real target agrees.
	assign pop_now  = allow && id_instr.jalr && (jalr_pred_en || jalr_data_match);
	assign push_now = allow && iclass.rd_is_ra && (id_instr.jal || id_instr.jalr);

	assign cmd.push = push_now;
	assign cmd.pop  = pop_now;

	// ************************************************************
	// rollback on flush
	// ************************************************************

	// the ex-side jump linked into ra and pushed.
	assign link_id = (rd_id == RA_IDX) && (jal_id || jalr_id);

	assign cmd.rb_pop_id  = pl_flush && link_id;
	assign cmd.rb_push_id = pl_flush && pop_id;
	assign cmd.rb_push_ex = pl_flush && pop_ex;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pop_id <= 1'b0;
			pop_ex <= 1'b0;
		end else if (!pl_stall_ex) begin
			pop_id <= pop_now;
			pop_ex <= pop_id;
		end
	end

	// ************************************************************
	// ra copy tracking
	// ************************************************************

	// remembers the destination of the last "mv rd, ra".
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			ra_track <= ZERO_IDX;
		end else if (iclass.track_mv) begin
			ra_track <= id_instr.rd;
		end
	end

endmodule

// File: src/return_addr_stack.sv
`timescale 1ns/100ps

module return_addr_stack
	import ras_pkg::*;
#(
	parameter int ADDR_W    = RAS_ADDR_W,
	parameter int RAS_DEPTH = 8
) (
	input  logic      clk,
	input  logic      rst_n,
	input  ras_cmd_t  cmd,
	input  ras_addr_t link_addr,
	output ras_addr_t ras_top
);

	localparam int PTR_W = $clog2(RAS_DEPTH);

	typedef logic [PTR_W-1:0] ras_ptr_t;

	logic [ADDR_W-1:0] entries [RAS_DEPTH];

	// points at the next free slot and wraps around.
	ras_ptr_t ptr;
	ras_ptr_t ptr_prev;
	ras_ptr_t ptr_rb;

	logic rb_any;
	logic push_only;
	logic pop_only;
	logic replace;

	assign ptr_prev = ptr - 1'b1;

	assign push_only = cmd.push && !cmd.pop;
	assign pop_only  = cmd.pop && !cmd.push;
	assign replace   = cmd.push && cmd.pop;

	// ************************************************************
	// rollback arithmetic
	// ************************************************************

	assign rb_any = cmd.rb_pop_id || cmd.rb_push_id || cmd.rb_push_ex;

	// popped entries stay in place, so moving the pointer restores them.
	assign ptr_rb = ptr
		+ PTR_W'(cmd.rb_push_id)
		+ PTR_W'(cmd.rb_push_ex)
		- PTR_W'(cmd.rb_pop_id);

	// ************************************************************
	// pointer and entries
	// ************************************************************

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			ptr <= '0;
		end else if (rb_any) begin
			ptr <= ptr_rb;
		end else if (push_only) begin
			ptr <= ptr + 1'b1;
		end else if (pop_only) begin
			ptr <= ptr_prev;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < RAS_DEPTH; i++) begin
				entries[i] <= '0;
			end
		end else if (!rb_any) begin
			if (replace) begin
				// a return and a call together swap the top entry.
				entries[ptr_prev] <= link_addr;
			end else if (push_only) begin
				entries[ptr] <= link_addr;
			end
		end
	end

	assign ras_top = entries[ptr_prev];

endmodule

// File: src/ctrl_unit_top.sv
`timescale 1ns/100ps

module ctrl_unit_top
	import pipe_pkg::*;
	import ras_pkg::*;
#(
	parameter int ADDR_W    = RAS_ADDR_W,
	parameter int RAS_DEPTH = 8
) (
	input  logic       clk,
	input  logic       rst_n,
	input  id_instr_t  id_instr,
	input  stage_src_t stage_id,
	input  stage_src_t stage_ex,
	input  stage_src_t stage_mem,
	input  stage_src_t stage_wb,
	input  logic       jal_id,
	input  logic       jalr_id,
	input  logic       pl_flush,
	input  logic       pl_stall_ex,
	input  logic       jalr_data_match,
	input  ras_addr_t  link_addr,
	output fwd_sel_t   rs1_fwd,
	output fwd_sel_t   rs2_fwd,
	output logic       b_pred_en,
	output logic       jalr_pred_en,
	output logic       stall_if,
	output logic       ras_push,
	output logic       ras_pop,
	output ras_addr_t  ras_top
);

	stage_src_t   srcs [N_STAGES];
	stage_hit_t   hits [N_STAGES];
	instr_class_t iclass;
	ras_cmd_t     cmd;
	reg_idx_t     ra_track;

	assign srcs[STG_ID]  = stage_id;
	assign srcs[STG_EX]  = stage_ex;
	assign srcs[STG_MEM] = stage_mem;
	assign srcs[STG_WB]  = stage_wb;

	// ************************************************************
	// hazard detection
	// ************************************************************

	instr_classify u_classify (
		.id_instr (id_instr),
		.ra_track (ra_track),
		.iclass   (iclass)
	);

	for (genvar s = 0; s < N_STAGES; s++) begin : g_stage_cmp
		stage_hazard_cmp u_cmp (
			.rs1 (id_instr.rs1),
			.rs2 (id_instr.rs2),
			.src (srcs[s]),
			.hit (hits[s])
		);
	end

	hazard_resolve u_resolve (
		.hits         (hits),
		.id_instr     (id_instr),
		.iclass       (iclass),
		.rs1_fwd      (rs1_fwd),
		.rs2_fwd      (rs2_fwd),
		.b_pred_en    (b_pred_en),
		.jalr_pred_en (jalr_pred_en),
		.stall_if     (stall_if)
	);

	// ************************************************************
	// return address prediction
	// ************************************************************

	ras_control u_ras_ctrl (
		.clk             (clk),
		.rst_n           (rst_n),
		.id_instr        (id_instr),
		.iclass          (iclass),
		.jal_id          (jal_id),
		.jalr_id         (jalr_id),
		.rd_id           (stage_id.rd),
		.pl_flush        (pl_flush),
		.pl_stall_ex     (pl_stall_ex),
		.stall_if        (stall_if),
		.jalr_pred_en    (jalr_pred_en),
		.jalr_data_match (jalr_data_match),
		.cmd             (cmd),
		.ra_track        (ra_track)
	);

	return_addr_stack #(
		.ADDR_W    (ADDR_W),
		.RAS_DEPTH (RAS_DEPTH)
	) u_ras (
		.clk       (clk),
		.rst_n     (rst_n),
		.cmd       (cmd),
		.link_addr (link_addr),
		.ras_top   (ras_top)
	);

	assign ras_push = cmd.push;
	assign ras_pop  = cmd.pop;

endmodule

// File: dv/ctrl_unit_tb.sv
`timescale 1ns/100ps

module ctrl_unit_tb
	import pipe_pkg::*;
	import ras_pkg::*;
();

	localparam int N_RANDOM = 200;

	// one directed vector with its expected responses.
	typedef struct packed {
		id_instr_t                 instr;
		stage_src_t [N_STAGES-1:0] stg;
		logic [4:0]                ctl;
		ras_addr_t                 link;
		fwd_sel_t                  exp_rs1_fwd;
		fwd_sel_t                  exp_rs2_fwd;
		logic [4:0]                exp_flags;
		ras_addr_t                 exp_top;
	} pattern_t;

	logic       clk;
	logic       rst_n;
	id_instr_t  id_instr;
	stage_src_t stg [N_STAGES];
	logic       jal_id;
	logic       jalr_id;
	logic       pl_flush;
	logic       pl_stall_ex;
	logic       jalr_data_match;
	ras_addr_t  link_addr;
	fwd_sel_t   rs1_fwd;
	fwd_sel_t   rs2_fwd;
	logic       b_pred_en;
	logic       jalr_pred_en;
	logic       stall_if;
	logic       ras_push;
	logic       ras_pop;
	ras_addr_t  ras_top;

	pattern_t    patterns [$];
	logic [15:0] lfsr = 16'd54;
	reg_idx_t    model_track;
	int          cycle_count = 0;
	int          cycle_limit = 1000;

	ctrl_unit_top #(
		.ADDR_W    (32),
		.RAS_DEPTH (8)
	) UUT (
		.clk             (clk),
		.rst_n           (rst_n),
		.id_instr        (id_instr),
		.stage_id        (stg[STG_ID]),
		.stage_ex        (stg[STG_EX]),
		.stage_mem       (stg[STG_MEM]),
		.stage_wb        (stg[STG_WB]),
		.jal_id          (jal_id),
		.jalr_id         (jalr_id),
		.pl_flush        (pl_flush),
		.pl_stall_ex     (pl_stall_ex),
		.jalr_data_match (jalr_data_match),
		.link_addr       (link_addr),
		.rs1_fwd         (rs1_fwd),
		.rs2_fwd         (rs2_fwd),
		.b_pred_en       (b_pred_en),
		.jalr_pred_en    (jalr_pred_en),
		.stall_if        (stall_if),
		.ras_push        (ras_push),
		.ras_pop         (ras_pop),
		.ras_top         (ras_top)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count > cycle_limit) begin
			$display("timeout: the run went past %0d cycles", cycle_limit);
			$display("TB FAILED");
			$fatal(1);
		end
	end

	// ************************************************************
	// checks and stimulus sources
	// ************************************************************

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		assert (got === exp) else begin
			$display("FAIL %0t %s expected %0h got %0h", $time, name, exp, got);
			$display("TB FAILED");
			$fatal(1);
		end
	endtask

	// flags are {b_pred_en, jalr_pred_en, stall_if, ras_push, ras_pop}.
	task automatic check_outputs(input fwd_sel_t e_rs1, input fwd_sel_t e_rs2,
		input logic [4:0] e_flags);
		check_value("rs1_fwd", rs1_fwd, e_rs1);
		check_value("rs2_fwd", rs2_fwd, e_rs2);
		check_value("b_pred_en", b_pred_en, e_flags[4]);
		check_value("jalr_pred_en", jalr_pred_en, e_flags[3]);
		check_value("stall_if", stall_if, e_flags[2]);
		check_value("ras_push", ras_push, e_flags[1]);
		check_value("ras_pop", ras_pop, e_flags[0]);
	endtask

	// galois lfsr stepped once per bit.
	function automatic logic take_bit();
		logic b;
		b = lfsr[0];
		lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
		return b;
	endfunction

	// small register range so that matches are frequent.
	function automatic reg_idx_t take_reg();
		reg_idx_t r;
		r = '0;
		for (int i = 0; i < 3; i++) begin
			r[i] = take_bit();
		end
		return r;
	endfunction

	task automatic load_patterns();
		int fd;
		int n;
		string line;
		logic [31:0] col [16];
		pattern_t p;
		fd = $fopen("dv/ctrl_patterns.txt", "r");
		if (fd == 0) begin
			$display("could not open the pattern file dv/ctrl_patterns.txt");
			$display("TB FAILED");
			$fatal(1);
		end
		while (!$feof(fd)) begin
			line = "";
			if ($fgets(line, fd) != 0 && line.len() > 1 && line[0] != "#") begin
				n = $sscanf(line, "%d %d %d %d %h %b %h %h %h %h %b %h %b %b %b %h",
					col[0], col[1], col[2], col[3], col[4], col[5], col[6], col[7],
					col[8], col[9], col[10], col[11], col[12], col[13], col[14], col[15]);
				if (n != 16) begin
					$display("pattern file has a malformed line: %s", line);
					$display("TB FAILED");
					$fatal(1);
				end
				p = '0;
				p.instr.rs1   = col[0][4:0];
				p.instr.rs2   = col[1][4:0];
				p.instr.rd    = col[2][4:0];
				p.instr.func3 = col[3][2:0];
				p.instr.imme  = col[4][11:0];
				{p.instr.i_type, p.instr.b_type, p.instr.jal, p.instr.jalr} = col[5][3:0];
				for (int s = 0; s < N_STAGES; s++) begin
					p.stg[s] = col[6+s][6:0];
				end
				p.ctl         = col[10][4:0];
				p.link        = col[11];
				p.exp_rs1_fwd = col[12][1:0];
				p.exp_rs2_fwd = col[13][1:0];
				p.exp_flags   = col[14][4:0];
				p.exp_top     = col[15];
				patterns.push_back(p);
			end
		end
		$fclose(fd);
		if (patterns.size() == 0) begin
			$display("the pattern file holds no vectors");
			$display("TB FAILED");
			$fatal(1);
		end
	endtask

	// ************************************************************
	// reference model of the hazard rules
	// ************************************************************

	task automatic predict(output fwd_sel_t e_rs1, output fwd_sel_t e_rs2,
		output logic [4:0] e_flags);
		logic [N_STAGES-1:0] h1;
		logic [N_STAGES-1:0] h2;
		logic early1;
		logic early2;
		logic is_ret;
		logic stall;
		logic allow;
		logic pred;
		for (int s = 0; s < N_STAGES; s++) begin
			h1[s] = stg[s].reg_write && (stg[s].rd == id_instr.rs1);
			h2[s] = stg[s].reg_write && (stg[s].rd == id_instr.rs2);
		end
		e_rs1 = {h1[STG_MEM] && !stg[STG_MEM].mem_read, h1[STG_WB]};
		e_rs2 = {h2[STG_MEM] && !stg[STG_MEM].mem_read, h2[STG_WB]};
		early1 = h1[STG_ID] || h1[STG_EX] || (h1[STG_MEM] && stg[STG_MEM].mem_read);
		early2 = h2[STG_ID] || h2[STG_EX] || (h2[STG_MEM] && stg[STG_MEM].mem_read);
		is_ret = (id_instr.rd == ZERO_IDX && id_instr.rs1 == RA_IDX && id_instr.imme == 0)
			|| (id_instr.rs1 == model_track && id_instr.rs1 != RA_IDX);
		pred = id_instr.jalr && is_ret && early1;
		stall = id_instr.jalr && !is_ret && !h1[STG_ID]
			&& ((h1[STG_EX] && !stg[STG_EX].mem_read)
			|| (h1[STG_MEM] && stg[STG_MEM].mem_read));
		allow = !pl_flush && !pl_stall_ex && !stall;
		e_flags[4] = id_instr.b_type && (early1 || early2);
		e_flags[3] = pred;
		e_flags[2] = stall;
		e_flags[1] = allow && (id_instr.rd == RA_IDX) && (id_instr.jal || id_instr.jalr);
		e_flags[0] = allow && id_instr.jalr && (pred || jalr_data_match);
	endtask

	// follows "mv rd, ra" at the clock edge.
	task automatic note_track();
		if (id_instr.i_type && id_instr.func3 == 3'b000 && id_instr.imme == 0
			&& id_instr.rs1 == RA_IDX) begin
			model_track = id_instr.rd;
		end
	endtask

	// ************************************************************
	// per-cycle sequences
	// ************************************************************

	task automatic run_pattern(input pattern_t p);
		id_instr = p.instr;
		for (int s = 0; s < N_STAGES; s++) begin
			stg[s] = p.stg[s];
		end
		{jal_id, jalr_id, pl_flush, pl_stall_ex, jalr_data_match} = p.ctl;
		link_addr = p.link;
		#36;
		check_outputs(p.exp_rs1_fwd, p.exp_rs2_fwd, p.exp_flags);
		@(posedge clk);
		note_track();
		#2;
		check_value("ras_top", ras_top, p.exp_top);
	endtask

	task automatic run_random_cycle();
		fwd_sel_t e_rs1;
		fwd_sel_t e_rs2;
		logic [4:0] e_flags;
		id_instr = '0;
		id_instr.rs1    = take_reg();
		id_instr.rs2    = take_reg();
		id_instr.rd     = take_reg();
		id_instr.imme   = {11'd0, take_bit()};
		id_instr.i_type = take_bit();
		id_instr.b_type = take_bit();
		id_instr.jal    = take_bit();
		id_instr.jalr   = take_bit();
		for (int s = 0; s < N_STAGES; s++) begin
			stg[s].rd        = take_reg();
			stg[s].reg_write = take_bit();
			stg[s].mem_read  = take_bit();
		end
		jalr_data_match = take_bit();
		// flush and ex stall stay rare.
		pl_flush    = take_bit() && take_bit() && take_bit();
		pl_stall_ex = take_bit() && take_bit() && take_bit();
		#36;
		predict(e_rs1, e_rs2, e_flags);
		check_outputs(e_rs1, e_rs2, e_flags);
		@(posedge clk);
		note_track();
		#2;
	endtask

	initial begin
		rst_n           = 1'b0;
		id_instr        = '0;
		jal_id          = 1'b0;
		jalr_id         = 1'b0;
		pl_flush        = 1'b0;
		pl_stall_ex     = 1'b0;
		jalr_data_match = 1'b0;
		link_addr       = '0;
		model_track     = ZERO_IDX;
		for (int s = 0; s < N_STAGES; s++) begin
			stg[s] = '0;
		end
		load_patterns();
		cycle_limit = patterns.size() + N_RANDOM + 20;
		repeat (3) @(posedge clk);
		#2;
		rst_n = 1'b1;
		check_value("ras_top", ras_top, 32'h0);
		foreach (patterns[i]) begin
			run_pattern(patterns[i]);
		end
		repeat (N_RANDOM) begin
			run_random_cycle();
		end
		$display("TB PASSED");
		$finish;
	end

endmodule

// File: dv/ctrl_patterns.txt
# rs1 rs2 rd f3 imm flags(i_type b_type jal jalr) id ex mem wb (hex {rd,reg_write,mem_read})
# ctl(jal_id jalr_id flush stall_ex data_match) link  rs1_fwd rs2_fwd out(b jalr stall push pop) top
3 4 5 0 000 0000 00 00 00 00 00100 00000000  00 00 00000 00000000
3 4 5 0 000 0000 00 00 00 0e 00000 00000000  01 00 00000 00000000
3 4 5 0 000 0000 00 00 12 00 00000 00000000  00 10 00000 00000000
3 4 5 0 000 0000 00 00 0f 00 00000 00000000  00 00 00000 00000000
3 4 5 0 000 0000 00 00 10 0c 00000 00000000  00 00 00000 00000000
3 4 5 0 000 0000 00 00 0e 12 00000 00000000  10 01 00000 00000000
3 4 5 0 000 0100 00 00 00 00 00000 00000000  00 00 00000 00000000
3 4 5 0 000 0100 12 00 00 00 00000 00000000  00 00 10000 00000000
3 4 5 0 000 0100 00 0e 00 00 00000 00000000  00 00 10000 00000000
3 4 5 0 000 0100 00 00 13 00 00000 00000000  00 00 10000 00000000
3 4 5 0 000 0100 00 00 12 00 00000 00000000  00 10 00000 00000000
3 4 1 0 000 0010 00 00 00 00 00000 00001000  00 00 00010 00001000
3 4 1 0 000 0010 00 00 00 00 00000 00002000  00 00 00010 00002000
3 4 1 0 000 0010 00 00 00 00 00000 00003000  00 00 00010 00003000
1 0 0 0 000 0001 00 00 00 00 00001 00000000  00 00 00001 00002000
1 0 0 0 000 0001 00 00 00 00 00001 00000000  00 00 00001 00001000
5 0 1 0 000 0001 00 00 00 00 00001 00004000  00 00 00011 00004000
3 4 1 0 000 0010 00 00 00 00 00000 00005000  00 00 00010 00005000
1 0 0 0 000 0001 00 00 00 00 00001 00000000  00 00 00001 00004000
3 4 5 0 000 0000 00 00 00 00 00100 00000000  00 00 00000 00005000
3 4 1 0 000 0010 00 00 00 00 00000 00006000  00 00 00010 00006000
3 4 5 0 000 0000 06 00 00 00 10100 00000000  00 00 00000 00005000
5 4 1 0 000 0001 00 16 00 00 00001 00008000  00 00 00100 00005000
5 4 0 0 000 0001 00 00 17 00 00000 00000000  00 00 00100 00005000
5 4 0 0 000 0001 16 16 00 00 00000 00000000  00 00 00000 00005000
3 4 1 0 000 0010 00 00 00 00 00000 00007000  00 00 00010 00007000
1 0 0 0 000 0001 06 00 00 00 00000 00000000  00 00 01001 00005000
1 0 0 0 000 0001 00 07 00 00 00000 00000000  00 00 01001 00004000
1 0 0 0 000 0001 00 00 06 00 00000 00000000  10 00 00000 00004000
1 0 0 0 000 0001 00 00 07 00 00010 00000000  00 00 01000 00004000
1 0 6 0 000 1000 00 00 00 00 00000 00000000  00 00 00000 00004000
6 0 0 0 000 0001 00 1a 00 00 00000 00000000  00 00 01001 00000000
1 0 7 0 004 1000 00 00 00 00 00000 00000000  00 00 00000 00000000
7 0 0 0 000 0001 00 1e 00 00 00000 00000000  00 00 00100 00000000
3 4 5 0 000 0000 00 00 00 00 00000 00000000  00 00 00000 00000000

// File: sources.f
src/pipe_pkg.sv
src/ras_pkg.sv
src/instr_classify.sv
src/stage_hazard_cmp.sv
src/hazard_resolve.sv
src/ras_control.sv
src/return_addr_stack.sv
src/ctrl_unit_top.sv
dv/ctrl_unit_tb.sv
